// File: all.f
common/rob_pkg.sv
common/txn_pkg.sv
reorder_buffer/reorder_buffer_memory.sv
reorder_buffer/reorder_buffer_controller.sv
source/completion_engine.sv
source/retire_stage.sv
source/reorder_unit.sv
test/reorder_unit_tb.sv

// File: Makefile
# Verilator flow for the reorder unit

VERILATOR ?= verilator
TOP       ?= reorder_unit_tb
RTL_TOP   ?= reorder_unit
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

FAIL_TEXT := *** TEST FAILED ***
PASS_TEXT := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_TEXT)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '$(PASS_TEXT)' $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/reorder_unit_tb.sv
// Reorder unit testbench
`timescale 1ns/1ps

module reorder_unit_tb import rob_pkg::*, txn_pkg::*; ();

  localparam int          DEPTH = 8;
  localparam int          LANES = 4;
  localparam logic [31:0] SEED  = 32'h407a;
  // Random stream is 300 requests at well under 20 cycles each
  // Directed tests and idle checks add only a few hundred more
  localparam int          MAX_CYCLES = 20000;

  logic      clock;
  logic      resetn;
  logic      req_valid;
  logic      req_ready;
  request_t  req;
  logic      rsp_valid;
  logic      rsp_ready;
  response_t rsp;

  // Reference model, one entry per accepted request
  response_t   expected_q [$];
  seq_t        next_seq;
  int          response_count;
  int          cycle_count;
  int          error_count;
  // Two random streams, requests and back-pressure
  logic [31:0] request_rand;
  logic [31:0] ready_rand;

  reorder_unit #(
    .DEPTH (DEPTH),
    .LANES (LANES)
  ) reorder_unit_i (
    .clock     (clock),
    .resetn    (resetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic compare_response(input string what, input response_t actual,
                                  input response_t expected);
    if (actual !== expected) begin
      abort_run($sformatf(
        "MISMATCH at %0t: %s seq %0d result 0x%04h, expected seq %0d result 0x%04h",
        $time, what, actual.seq, actual.result, expected.seq, expected.result));
    end
  endtask

  task automatic compare_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                          $time, what, actual, expected));
    end
  endtask

  // Drive point, just after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // Hold the request until the edge that takes it
  task automatic send_request(input operand_t operand);
    req_valid   = 1'b1;
    req.operand = operand;
    @(negedge clock);
    while (!req_ready) @(negedge clock);
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic drain_responses();
    while (expected_q.size() != 0) next_cycle();
  endtask

  // Nothing may come out of an empty unit
  task automatic idle_check();
    rsp_ready = 1'b1;
    repeat (6) begin
      @(negedge clock);
      compare_flag("rsp_valid while idle", rsp_valid, 1'b0);
      next_cycle();
    end
    compare_flag("model queue empty", expected_q.size() == 0, 1'b1);
  endtask

  // Model update and response check, sampled mid-cycle
  always @(negedge clock) begin : monitor
    response_t model;
    if (resetn) begin
      if (req_valid && req_ready) begin
        model.seq    = next_seq;
        model.result = req.operand + result_t'(1);
        expected_q.push_back(model);
        next_seq = next_seq + seq_t'(1);
      end
      if (rsp_valid && rsp_ready) begin
        if (expected_q.size() == 0) begin
          abort_run("Response seen with no request outstanding");
        end else begin
          compare_response("response", rsp, expected_q.pop_front());
          response_count++;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      abort_run("Timeout, the DUT did not finish within the cycle limit");
    end
  end

  task automatic reset_idle();
    repeat (5) begin
      @(negedge clock);
      compare_flag("req_ready after reset", req_ready, 1'b1);
      compare_flag("rsp_valid after reset", rsp_valid, 1'b0);
      next_cycle();
    end
  endtask

  // First request ever, so the model expects seq 0
  task automatic single_request();
    rsp_ready = 1'b1;
    send_request(16'h1230);
    drain_responses();
    compare_flag("one response", response_count == 1, 1'b1);
  endtask

  // Later requests finish first, low bits 3 2 1 0
  task automatic falling_burst();
    rsp_ready = 1'b1;
    for (int i = 0; i < 8; i++) begin
      request_rand = lcg_step(request_rand);
      send_request({request_rand[31:18], 2'(3 - (i % 4))});
    end
    drain_responses();
  endtask

  task automatic full_backpressure();
    response_t held;
    int        low_cycles;
    logic      holding;
    logic      accepted;
    rsp_ready    = 1'b0;
    low_cycles   = 0;
    holding      = 1'b0;
    request_rand = lcg_step(request_rand);
    req.operand  = request_rand[31:16];
    req_valid    = 1'b1;
    // Keep offering until the unit stays closed longer than any latency
    while (low_cycles < 16) begin
      @(negedge clock);
      if (holding) begin
        compare_response("stalled response", rsp, held);
      end else if (rsp_valid) begin
        held    = rsp;
        holding = 1'b1;
      end
      accepted = req_ready;
      if (req_ready) low_cycles = 0;
      else low_cycles++;
      next_cycle();
      if (accepted) begin
        request_rand = lcg_step(request_rand);
        req.operand  = request_rand[31:16];
      end
    end
    req_valid = 1'b0;
    compare_flag("req_ready with buffer full", req_ready, 1'b0);
    compare_flag("rsp_valid with buffer full", rsp_valid, 1'b1);
    compare_flag("DEPTH requests outstanding", expected_q.size() >= DEPTH, 1'b1);
    rsp_ready = 1'b1;
    drain_responses();
    @(negedge clock);
    compare_flag("req_ready after drain", req_ready, 1'b1);
    next_cycle();
  endtask

  // Sequence number wraps past 255 in here
  task automatic random_stream();
    int   start_count;
    logic sending;
    start_count = response_count;
    sending     = 1'b1;
    fork
      begin
        for (int i = 0; i < 300; i++) begin
          request_rand = lcg_step(request_rand);
          if (request_rand[23:22] == 2'b00) next_cycle();
          send_request(request_rand[31:16]);
        end
        sending = 1'b0;
      end
      begin
        while (sending) begin
          ready_rand = lcg_step(ready_rand);
          rsp_ready  = ready_rand[31:30] != 2'b00;
          next_cycle();
        end
      end
    join
    rsp_ready = 1'b1;
    drain_responses();
    compare_flag("300 responses", (response_count - start_count) == 300, 1'b1);
  endtask

  initial begin
    resetn         = 1'b0;
    req_valid      = 1'b0;
    req            = '0;
    rsp_ready      = 1'b0;
    next_seq       = '0;
    response_count = 0;
    cycle_count    = 0;
    error_count    = 0;
    request_rand   = SEED;
    // Second stream from the inverted seed
    ready_rand     = ~SEED;
    repeat (8) @(posedge clock);
    #1;
    resetn = 1'b1;

    reset_idle();
    idle_check();
    single_request();
    idle_check();
    falling_burst();
    idle_check();
    full_backpressure();
    idle_check();
    random_stream();
    idle_check();

    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: source/reorder_unit.sv
// Reorder unit top level
`timescale 1ns/1ps

module reorder_unit import rob_pkg::*, txn_pkg::*; #(
  parameter int DEPTH = ROB_DEPTH_DEFAULT,
  parameter int LANES = 4
) (
  input             clock,
  input             resetn,
  // Requests in program order
  input             req_valid,
  output            req_ready,
  input  request_t  req,
  // Responses restored to program order
  output            rsp_valid,
  input             rsp_ready,
  output response_t rsp
);

  localparam int INDEX_WIDTH = $clog2(DEPTH);

  // Engine to controller
  logic                   reserve_enable;
  logic [INDEX_WIDTH-1:0] reserve_index;
  logic                   reserve_full;
  logic                   write_enable;
  logic [INDEX_WIDTH-1:0] write_index;
  rob_entry_t             write_entry;

  // Retire side
  logic                   head_valid;
  logic                   read_enable;
  logic [INDEX_WIDTH-1:0] memory_read_address;
  rob_entry_t             read_entry;

  completion_engine #(
    .DEPTH (DEPTH),
    .LANES (LANES)
  ) completion_engine_i (
    .clock          (clock),
    .resetn         (resetn),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .reserve_enable (reserve_enable),
    .reserve_index  (reserve_index),
    .reserve_full   (reserve_full),
    .write_enable   (write_enable),
    .write_index    (write_index),
    .write_entry    (write_entry)
  );

  // Occupancy flags beyond full and head are not needed here
  reorder_buffer_controller #(
    .DEPTH       (DEPTH),
    .INDEX_WIDTH (INDEX_WIDTH)
  ) reorder_buffer_controller_i (
    .clock               (clock),
    .resetn              (resetn),
    .reserve_full        (reserve_full),
    .reserve_empty       (),
    .data_full           (),
    .data_empty          (),
    .head_valid          (head_valid),
    .reserve_enable      (reserve_enable),
    .reserve_index       (reserve_index),
    .write_enable        (write_enable),
    .write_index         (write_index),
    .read_enable         (read_enable),
    .memory_read_address (memory_read_address)
  );

  reorder_buffer_memory #(
    .DEPTH       (DEPTH),
    .INDEX_WIDTH (INDEX_WIDTH),
    .entry_t     (rob_entry_t)
  ) reorder_buffer_memory_i (
    .clock         (clock),
    .write_enable  (write_enable),
    .write_address (write_index),
    .write_data    (write_entry),
    .read_enable   (read_enable),
    .read_address  (memory_read_address),
    .read_data     (read_entry)
  );

  retire_stage retire_stage_i (
    .clock       (clock),
    .resetn      (resetn),
    .head_valid  (head_valid),
    .read_enable (read_enable),
    .read_entry  (read_entry),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp         (rsp)
  );

endmodule

// File: source/retire_stage.sv
// In-order retire stage
`timescale 1ns/1ps

module retire_stage import txn_pkg::*; (
  input              clock,
  input              resetn,
  // Buffer head
  input              head_valid,
  output logic       read_enable,
  input  rob_entry_t read_entry,
  // Response port
  output logic       rsp_valid,
  input              rsp_ready,
  output response_t  rsp
);

  // Memory output holds an entry not yet moved to rsp
  logic in_flight;
  logic load_output;

  // Move the memory output once rsp has room
  assign load_output = in_flight && (!rsp_valid || rsp_ready);
  // New read only when the memory output is free or freeing up
  assign read_enable = head_valid && (!in_flight || load_output);

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      in_flight <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (read_enable) in_flight <= 1'b1;
      else if (load_output) in_flight <= 1'b0;
      if (load_output) rsp_valid <= 1'b1;
      else if (rsp_ready) rsp_valid <= 1'b0;
    end
  end

  // Response register
  always_ff @(posedge clock) begin
    if (load_output) begin
      rsp.seq    <= read_entry.seq;
      rsp.result <= read_entry.result;
    end
  end

  // Stalled response stays put
  assert property (@(posedge clock) disable iff (!resetn)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// File: source/completion_engine.sv
// Out-of-order completion engine
`timescale 1ns/1ps

module completion_engine import rob_pkg::*, txn_pkg::*; #(
  parameter int DEPTH = ROB_DEPTH_DEFAULT,
  parameter int LANES = 4
) (
  input                               clock,
  input                               resetn,
  // Request port
  input                               req_valid,
  output logic                        req_ready,
  input  request_t                    req,
  // Reservation port
  output logic                        reserve_enable,
  input        [$clog2(DEPTH)-1:0]    reserve_index,
  input                               reserve_full,
  // Write-back port
  output logic                        write_enable,
  output logic [$clog2(DEPTH)-1:0]    write_index,
  output rob_entry_t                  write_entry
);

  localparam int INDEX_WIDTH = $clog2(DEPTH);
  localparam int LANE_WIDTH  = (LANES > 1) ? $clog2(LANES) : 1;

  // What a lane carries while it runs
  typedef struct packed {
    logic [INDEX_WIDTH-1:0] slot;
    rob_entry_t             entry;
  } lane_payload_t;

  // Lane control state
  logic     [LANES-1:0] busy;
  latency_t             count [LANES];
  // Lane payload
  lane_payload_t        payload [LANES];

  // Next sequence number to hand out
  seq_t next_seq;

  logic                  lane_free;
  logic [LANE_WIDTH-1:0] free_lane;
  logic [LANES-1:0]      done;
  logic [LANE_WIDTH-1:0] win_lane;
  logic                  accept;

  // Lowest free lane
  always_comb begin
    free_lane = '0;
    for (int i = LANES - 1; i >= 0; i--) begin
      if (!busy[i]) free_lane = LANE_WIDTH'(i);
    end
  end
  assign lane_free = ~&busy;

  // Accept only with a lane and a slot available
  assign req_ready      = lane_free && !reserve_full;
  assign accept         = req_valid && req_ready;
  assign reserve_enable = accept;

  // Lanes whose countdown has run out
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      done[i] = busy[i] && (count[i] == '0);
    end
  end

  // Fixed priority, lowest finished lane wins
  always_comb begin
    win_lane = '0;
    for (int i = LANES - 1; i >= 0; i--) begin
      if (done[i]) win_lane = LANE_WIDTH'(i);
    end
  end

  assign write_enable = |done;
  assign write_index  = payload[win_lane].slot;
  assign write_entry  = payload[win_lane].entry;

  // Lane start, countdown and release
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      busy     <= '0;
      count    <= '{default: '0};
      next_seq <= '0;
    end else begin
      for (int i = 0; i < LANES; i++) begin
        if (accept && free_lane == LANE_WIDTH'(i)) begin
          busy[i]  <= 1'b1;
          count[i] <= op_latency(req.operand);
        end else if (write_enable && win_lane == LANE_WIDTH'(i)) begin
          busy[i] <= 1'b0;
        end else if (busy[i] && count[i] != '0) begin
          count[i] <= count[i] - latency_t'(1);
        end
      end
      // Stamp order at acceptance
      if (accept) next_seq <= next_seq + seq_t'(1);
    end
  end

  // Slot and result captured when the lane starts
  always_ff @(posedge clock) begin
    if (accept) begin
      payload[free_lane].slot         <= reserve_index;
      payload[free_lane].entry.seq    <= next_seq;
      payload[free_lane].entry.result <= op_result(req.operand);
    end
  end

  // A write-back never lands on the slot being reserved
  assert property (@(posedge clock) disable iff (!resetn)
    write_enable && accept |-> write_index != reserve_index);

endmodule

// File: reorder_buffer/reorder_buffer_controller.sv
// Reorder buffer pointer and flag control
`timescale 1ns/1ps

module reorder_buffer_controller import rob_pkg::*; #(
  parameter int DEPTH       = ROB_DEPTH_DEFAULT,
  parameter int INDEX_WIDTH = $clog2(DEPTH)
) (
  input                          clock,
  input                          resetn,
  // Status flags
  output logic                   reserve_full,
  output logic                   reserve_empty,
  output logic                   data_full,
  output logic                   data_empty,
  output logic                   head_valid,
  // Reservation
  input                          reserve_enable,
  output logic [INDEX_WIDTH-1:0] reserve_index,
  // Out-of-order write
  input                          write_enable,
  input        [INDEX_WIDTH-1:0] write_index,
  // In-order read
  input                          read_enable,
  output logic [INDEX_WIDTH-1:0] memory_read_address
);

  // Slot state
  logic [DEPTH-1:0] reserved;
  logic [DEPTH-1:0] reserved_next;
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] valid_next;

  // Pointers, top bit is the wrap bit
  logic [INDEX_WIDTH:0] reserve_pointer;
  logic [INDEX_WIDTH:0] reserve_pointer_next;
  logic [INDEX_WIDTH:0] read_pointer;
  logic [INDEX_WIDTH:0] read_pointer_next;

  logic reserve_full_next;
  logic reserve_empty_next;
  logic data_full_next;
  logic data_empty_next;
  logic head_valid_next;

  // Same index, wrap bits differ when full and match when empty
  assign reserve_full_next =
    reserve_pointer_next[INDEX_WIDTH-1:0] == read_pointer_next[INDEX_WIDTH-1:0] &&
    reserve_pointer_next[INDEX_WIDTH]     != read_pointer_next[INDEX_WIDTH];
  assign reserve_empty_next = reserve_pointer_next == read_pointer_next;

  assign data_full_next  = &valid_next;
  assign data_empty_next = ~|valid_next;
  // Head ready once its result has landed
  assign head_valid_next = valid_next[read_pointer_next[INDEX_WIDTH-1:0]];

  // Next state for reserve, write and read
  always_comb begin
    reserve_pointer_next = reserve_pointer;
    read_pointer_next    = read_pointer;
    reserved_next        = reserved;
    valid_next           = valid;
    if (reserve_enable) begin
      reserved_next[reserve_pointer[INDEX_WIDTH-1:0]] = 1'b1;
      reserve_pointer_next = reserve_pointer + 1'b1;
    end
    if (write_enable) begin
      valid_next[write_index] = 1'b1;
    end
    // Retire frees the slot for reuse
    if (read_enable) begin
      valid_next[read_pointer[INDEX_WIDTH-1:0]]    = 1'b0;
      reserved_next[read_pointer[INDEX_WIDTH-1:0]] = 1'b0;
      read_pointer_next = read_pointer + 1'b1;
    end
  end

  assign reserve_index       = reserve_pointer[INDEX_WIDTH-1:0];
  assign memory_read_address = read_pointer[INDEX_WIDTH-1:0];

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserve_full    <= 1'b0;
      reserve_empty   <= 1'b1;
      data_full       <= 1'b0;
      data_empty      <= 1'b1;
      head_valid      <= 1'b0;
      reserve_pointer <= '0;
      read_pointer    <= '0;
      reserved        <= '0;
      valid           <= '0;
    end else begin
      reserve_full    <= reserve_full_next;
      reserve_empty   <= reserve_empty_next;
      data_full       <= data_full_next;
      data_empty      <= data_empty_next;
      head_valid      <= head_valid_next;
      reserve_pointer <= reserve_pointer_next;
      read_pointer    <= read_pointer_next;
      reserved        <= reserved_next;
      valid           <= valid_next;
    end
  end

  // Engine honours the full flag
  assert property (@(posedge clock) disable iff (!resetn)
    reserve_enable |-> !reserve_full);

  // Results only go to live, unfilled slots
  assert property (@(posedge clock) disable iff (!resetn)
    write_enable |-> reserved[write_index] && !valid[write_index]);

  // Retire stage reads only a filled head
  assert property (@(posedge clock) disable iff (!resetn)
    read_enable |-> head_valid);

endmodule

// File: reorder_buffer/reorder_buffer_memory.sv
// Reorder buffer slot storage
`timescale 1ns/1ps

module reorder_buffer_memory import rob_pkg::*; #(
  parameter int  DEPTH       = ROB_DEPTH_DEFAULT,
  parameter int  INDEX_WIDTH = $clog2(DEPTH),
  parameter type entry_t     = logic [31:0]
) (
  input                          clock,
  // Write port, any slot in any order
  input                          write_enable,
  input        [INDEX_WIDTH-1:0] write_address,
  input  entry_t                 write_data,
  // Read port, one cycle latency
  input                          read_enable,
  input        [INDEX_WIDTH-1:0] read_address,
  output entry_t                 read_data
);

  // Slot array, maps to block RAM
  entry_t slots [DEPTH];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      slots[write_address] <= write_data;
    end
  end

  // Output holds until the next read
  always_ff @(posedge clock) begin
    if (read_enable) begin
      read_data <= slots[read_address];
    end
  end

endmodule

// File: common/txn_pkg.sv
// Request and response payloads
package txn_pkg;

  import rob_pkg::*;

  // Low operand bits that select the base latency
  localparam int LATENCY_BITS  = 2;
  // One extra bit so that the +1 never overflows
  localparam int LATENCY_WIDTH = LATENCY_BITS + 1;

  typedef logic [15:0]              operand_t;
  typedef logic [15:0]              result_t;
  typedef logic [LATENCY_WIDTH-1:0] latency_t;

  // Incoming request
  typedef struct packed {
    operand_t operand;
  } request_t;

  // Outgoing response, tagged for order checking
  typedef struct packed {
    seq_t    seq;
    result_t result;
  } response_t;

  // Slot contents of the reorder buffer
  typedef struct packed {
    seq_t    seq;
    result_t result;
  } rob_entry_t;

  // Cycles a lane counts down before it asks to write
  function automatic latency_t op_latency(operand_t operand);
    return latency_t'(operand[LATENCY_BITS-1:0]) + latency_t'(1);
  endfunction

  // The operation itself
  function automatic result_t op_result(operand_t operand);
    return operand + result_t'(1);
  endfunction

endpackage

// File: common/rob_pkg.sv
// Reorder buffer shared types
package rob_pkg;

  // Sequence numbers are stamped at acceptance
  // and wrap silently at the top of the range
  localparam int SEQ_WIDTH = 8;

  // Free running counter type, one per request
  typedef logic [SEQ_WIDTH-1:0] seq_t;

  // Slot count used when the top level is not overridden
  // Must stay a power of two for the wrap-bit pointers
  localparam int ROB_DEPTH_DEFAULT = 8;

endpackage
